//--- hw/fp2_config.svh
// Fp2 arithmetic constants for field width, prime, reduction and pipeline depth
`ifndef FP2_CONFIG_SVH
`define FP2_CONFIG_SVH

// Element width and prime, p = 2^16 - 17
`define FP_BITS    16
`define FP_MODULUS 65519

// 2^16 mod p, folds the upper half of a product back into the lower half
`define FP_FOLD    17

// Fp multiplier latency in cycles
`define MUL_STAGES 3

// User tag carried with each operation
`define TAG_BITS   4

`endif

//--- hw/fp_field_pkg.sv
// Field element types, one Fp element and the Fp2 word with its two views
`include "fp2_config.svh"

package fp_field_pkg;

  // One Fp element
  typedef logic [`FP_BITS-1:0] fe_t;

  // Fp2 element split into its two halves, real part in the low half
  typedef struct packed {
    fe_t im;
    fe_t re;
  } fe2_parts_t;

  // Same word read flat at the ports or split by the sequencers
  typedef union packed {
    logic [2*`FP_BITS-1:0] raw;
    fe2_parts_t            parts;
  } fe2_u;

endpackage

//--- hw/fp2_op_pkg.sv
// Operation codes for the Fp2 block and requester ids for the shared add/sub unit
package fp2_op_pkg;

  // Fp2 operation selected with each start
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2
  } fp2_op_e;

  // Requester of the shared add/sub unit, also its result tag
  typedef enum logic {
    REQ_LIN = 1'b0,
    REQ_MUL = 1'b1
  } req_id_e;

endpackage

//--- hw/fp_mod_mul.sv
// Fp multiplier, pipelined with pseudo-Mersenne folding and a product index carried along
`timescale 1ns/1ns
`include "fp2_config.svh"

module fp_mod_mul (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_vld,
  input  fp_field_pkg::fe_t i_a,
  input  fp_field_pkg::fe_t i_b,
  input  logic [1:0]        i_idx,
  output logic              o_vld,
  output fp_field_pkg::fe_t o_p,
  output logic [1:0]        o_idx
);
  localparam int W  = `FP_BITS;
  // High half times the fold constant needs five extra bits, the add one more
  localparam int FW = W + 6;
  localparam logic [W-1:0] P = `FP_MODULUS;

  logic [2*W-1:0]         prod_q;
  logic [FW-1:0]          fold_q;
  logic [FW-1:0]          fold1_c;
  logic [W:0]             fold2_c;
  logic [`MUL_STAGES-1:0] vld_q;
  logic [1:0]             idx_q [`MUL_STAGES];

  // First fold, hi*2^16 + lo == hi*17 + lo
  assign fold1_c = FW'(prod_q[W-1:0]) + FW'(prod_q[2*W-1:W]) * FW'(`FP_FOLD);

  // Second fold leaves a value below 2p
  assign fold2_c = (W+1)'(fold_q[W-1:0]) + (W+1)'(fold_q[FW-1:W]) * (W+1)'(`FP_FOLD);

  always_ff @(posedge i_clk) begin
    prod_q <= i_a * i_b;
    fold_q <= fold1_c;
    o_p    <= (fold2_c >= {1'b0, P}) ? W'(fold2_c - {1'b0, P}) : fold2_c[W-1:0];
  end

  // Valid strobe and index ride along the data stages
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[`MUL_STAGES-2:0], i_vld};
    end
  end

  always_ff @(posedge i_clk) begin
    idx_q[0] <= i_idx;
    for (int s = 1; s < `MUL_STAGES; s++) begin
      idx_q[s] <= idx_q[s-1];
    end
  end

  assign o_vld = vld_q[`MUL_STAGES-1];
  assign o_idx = idx_q[`MUL_STAGES-1];

endmodule

//--- hw/fp_mod_addsub.sv
// Fp adder/subtractor, one cycle, with a single modular correction step
`timescale 1ns/1ns
`include "fp2_config.svh"

module fp_mod_addsub (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_vld,
  input  logic                i_sub,
  input  fp_field_pkg::fe_t   i_a,
  input  fp_field_pkg::fe_t   i_b,
  input  fp2_op_pkg::req_id_e i_id,
  output logic                o_vld,
  output fp_field_pkg::fe_t   o_r,
  output fp2_op_pkg::req_id_e o_id
);
  localparam int W = `FP_BITS;
  localparam logic [W-1:0] P = `FP_MODULUS;

  logic [W:0]   sum_c;
  logic [W:0]   dif_c;
  logic [W-1:0] res_c;

  always_comb begin
    sum_c = {1'b0, i_a} + {1'b0, i_b};
    dif_c = {1'b0, i_a} - {1'b0, i_b};
    if (i_sub) begin
      // Borrow out means a < b, add p back
      res_c = dif_c[W] ? dif_c[W-1:0] + P : dif_c[W-1:0];
    end else begin
      res_c = (sum_c >= {1'b0, P}) ? W'(sum_c - {1'b0, P}) : sum_c[W-1:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_vld <= 1'b0;
    end else begin
      o_vld <= i_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    o_r  <= res_c;
    o_id <= i_id;
  end

endmodule

//--- hw/fp_res_arbiter.sv
// Round-robin arbiter sharing the add/sub unit between the two Fp2 sequencers
`timescale 1ns/1ns

module fp_res_arbiter (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_req_lin,
  input  fp_field_pkg::fe_t   i_a_lin,
  input  fp_field_pkg::fe_t   i_b_lin,
  input  logic                i_sub_lin,
  output logic                o_gnt_lin,
  output logic                o_resp_lin,
  output fp_field_pkg::fe_t   o_r_lin,
  input  logic                i_req_mul,
  input  fp_field_pkg::fe_t   i_a_mul,
  input  fp_field_pkg::fe_t   i_b_mul,
  input  logic                i_sub_mul,
  output logic                o_gnt_mul,
  output logic                o_resp_mul,
  output fp_field_pkg::fe_t   o_r_mul,
  output logic                o_vld,
  output logic                o_sub,
  output fp_field_pkg::fe_t   o_a,
  output fp_field_pkg::fe_t   o_b,
  output fp2_op_pkg::req_id_e o_id,
  input  logic                i_vld,
  input  fp_field_pkg::fe_t   i_r,
  input  fp2_op_pkg::req_id_e i_id
);
  import fp2_op_pkg::*;

  // Last winner, the other requester has priority next
  req_id_e last_q;

  assign o_gnt_lin = i_req_lin && (!i_req_mul || last_q == REQ_MUL);
  assign o_gnt_mul = i_req_mul && !o_gnt_lin;

  assign o_vld = o_gnt_lin || o_gnt_mul;
  assign o_id  = o_gnt_mul ? REQ_MUL : REQ_LIN;
  assign o_a   = o_gnt_mul ? i_a_mul : i_a_lin;
  assign o_b   = o_gnt_mul ? i_b_mul : i_b_lin;
  assign o_sub = o_gnt_mul ? i_sub_mul : i_sub_lin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      last_q <= REQ_MUL;
    end else if (o_vld) begin
      last_q <= o_id;
    end
  end

  // Result goes back to whoever issued it
  assign o_resp_lin = i_vld && (i_id == REQ_LIN);
  assign o_resp_mul = i_vld && (i_id == REQ_MUL);
  assign o_r_lin    = i_r;
  assign o_r_mul    = i_r;

endmodule

//--- hw/fp2_linear_seq.sv
// Fp2 add/subtract sequencer, real then imaginary part through the shared add/sub unit
`timescale 1ns/1ns
`include "fp2_config.svh"

module fp2_linear_seq (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_start,
  input  logic                 i_sub,
  input  logic [`TAG_BITS-1:0] i_tag,
  input  fp_field_pkg::fe2_u   i_a,
  input  fp_field_pkg::fe2_u   i_b,
  output logic                 o_busy,
  output logic                 o_done,
  output logic [`TAG_BITS-1:0] o_tag,
  output fp_field_pkg::fe2_u   o_r,
  output logic                 o_req,
  output fp_field_pkg::fe_t    o_ua,
  output fp_field_pkg::fe_t    o_ub,
  output logic                 o_usub,
  input  logic                 i_gnt,
  input  logic                 i_resp,
  input  fp_field_pkg::fe_t    i_ur
);
  import fp_field_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_RE, S_IM, S_WAIT} state_e;

  state_e state_q;
  fe2_u   a_q;
  fe2_u   b_q;
  logic   sub_q;
  logic   got_re_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q  <= S_IDLE;
      got_re_q <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state_q)
        S_IDLE: if (i_start) state_q <= S_RE;
        S_RE:   if (i_gnt) state_q <= S_IM;
        S_IM:   if (i_gnt) state_q <= S_WAIT;
        default: ;
      endcase
      // Responses come back in grant order, real part first
      if (i_resp) begin
        got_re_q <= ~got_re_q;
        if (got_re_q) begin
          o_done  <= 1'b1;
          state_q <= S_IDLE;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start && state_q == S_IDLE) begin
      a_q   <= i_a;
      b_q   <= i_b;
      sub_q <= i_sub;
      o_tag <= i_tag;
    end
    if (i_resp) begin
      if (got_re_q) begin
        o_r.parts.im <= i_ur;
      end else begin
        o_r.parts.re <= i_ur;
      end
    end
  end

  assign o_busy = (state_q != S_IDLE);
  assign o_req  = (state_q == S_RE) || (state_q == S_IM);
  assign o_ua   = (state_q == S_IM) ? a_q.parts.im : a_q.parts.re;
  assign o_ub   = (state_q == S_IM) ? b_q.parts.im : b_q.parts.re;
  assign o_usub = sub_q;

endmodule

//--- hw/fp2_mul_seq.sv
// Fp2 multiply sequencer, four Fp products then ac-bd and ad+bc on the shared unit
`timescale 1ns/1ns
`include "fp2_config.svh"

module fp2_mul_seq (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_start,
  input  logic [`TAG_BITS-1:0] i_tag,
  input  fp_field_pkg::fe2_u   i_a,
  input  fp_field_pkg::fe2_u   i_b,
  output logic                 o_busy,
  output logic                 o_done,
  output logic [`TAG_BITS-1:0] o_tag,
  output fp_field_pkg::fe2_u   o_r,
  output logic                 o_mvld,
  output fp_field_pkg::fe_t    o_ma,
  output fp_field_pkg::fe_t    o_mb,
  output logic [1:0]           o_midx,
  input  logic                 i_pvld,
  input  fp_field_pkg::fe_t    i_p,
  input  logic [1:0]           i_pidx,
  output logic                 o_req,
  output fp_field_pkg::fe_t    o_ua,
  output fp_field_pkg::fe_t    o_ub,
  output logic                 o_usub,
  input  logic                 i_gnt,
  input  logic                 i_resp,
  input  fp_field_pkg::fe_t    i_ur
);
  import fp_field_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_ISSUE, S_PROD, S_SUB, S_ADD, S_WAIT} state_e;

  state_e     state_q;
  logic [1:0] cnt_q;
  logic       got_re_q;
  fe2_u       a_q;
  fe2_u       b_q;
  // Products by index: 0 ac, 1 bd, 2 ad, 3 bc
  fe_t        prod_q [4];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q  <= S_IDLE;
      cnt_q    <= 2'd0;
      got_re_q <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state_q)
        S_IDLE: if (i_start) state_q <= S_ISSUE;
        S_ISSUE: begin
          // Counter wraps back to zero after the fourth product
          cnt_q <= cnt_q + 2'd1;
          if (cnt_q == 2'd3) state_q <= S_PROD;
        end
        // Pipeline is in order, so bc arriving means all four are in
        S_PROD: if (i_pvld && i_pidx == 2'd3) state_q <= S_SUB;
        S_SUB:  if (i_gnt) state_q <= S_ADD;
        S_ADD:  if (i_gnt) state_q <= S_WAIT;
        default: ;
      endcase
      if (i_resp) begin
        got_re_q <= ~got_re_q;
        if (got_re_q) begin
          o_done  <= 1'b1;
          state_q <= S_IDLE;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start && state_q == S_IDLE) begin
      a_q   <= i_a;
      b_q   <= i_b;
      o_tag <= i_tag;
    end
    if (i_pvld) begin
      prod_q[i_pidx] <= i_p;
    end
    // ac-bd is granted first, so the first response is the real part
    if (i_resp) begin
      if (got_re_q) begin
        o_r.parts.im <= i_ur;
      end else begin
        o_r.parts.re <= i_ur;
      end
    end
  end

  // Operand select per index, a.im on odd indices, b.im on indices 1 and 2
  assign o_mvld = (state_q == S_ISSUE);
  assign o_midx = cnt_q;
  assign o_ma   = cnt_q[0] ? a_q.parts.im : a_q.parts.re;
  assign o_mb   = (cnt_q[0] ^ cnt_q[1]) ? b_q.parts.im : b_q.parts.re;

  assign o_busy = (state_q != S_IDLE);
  assign o_req  = (state_q == S_SUB) || (state_q == S_ADD);
  assign o_ua   = (state_q == S_ADD) ? prod_q[2] : prod_q[0];
  assign o_ub   = (state_q == S_ADD) ? prod_q[3] : prod_q[1];
  assign o_usub = (state_q == S_SUB);

endmodule

//--- hw/fp2_op_router.sv
// Start dispatch to the Fp2 peers with drop on busy, and merge of their done strobes
`timescale 1ns/1ns
`include "fp2_config.svh"

module fp2_op_router (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_start,
  input  fp2_op_pkg::fp2_op_e     i_op,
  input  logic [`TAG_BITS-1:0]    i_tag,
  input  logic [2*`FP_BITS-1:0]   i_a,
  input  logic [2*`FP_BITS-1:0]   i_b,
  output logic                    o_drop,
  output logic                    o_lin_start,
  output logic                    o_lin_sub,
  output logic                    o_mul_start,
  output logic [`TAG_BITS-1:0]    o_fwd_tag,
  output fp_field_pkg::fe2_u      o_fwd_a,
  output fp_field_pkg::fe2_u      o_fwd_b,
  input  logic                    i_lin_busy,
  input  logic                    i_lin_done,
  input  logic [`TAG_BITS-1:0]    i_lin_tag,
  input  fp_field_pkg::fe2_u      i_lin_r,
  input  logic                    i_mul_busy,
  input  logic                    i_mul_done,
  input  logic [`TAG_BITS-1:0]    i_mul_tag,
  input  fp_field_pkg::fe2_u      i_mul_r,
  output logic                    o_done,
  output logic [`TAG_BITS-1:0]    o_done_tag,
  output logic [2*`FP_BITS-1:0]   o_result
);
  import fp2_op_pkg::*;

  logic                  to_mul;
  logic                  busy_c;
  logic                  hold_vld_q;
  logic [`TAG_BITS-1:0]  hold_tag_q;
  logic [2*`FP_BITS-1:0] hold_r_q;

  assign to_mul      = (i_op == OP_MUL);
  assign busy_c      = to_mul ? i_mul_busy : i_lin_busy;
  assign o_lin_start = i_start && !to_mul && !i_lin_busy;
  assign o_mul_start = i_start && to_mul && !i_mul_busy;
  assign o_lin_sub   = (i_op == OP_SUB);
  assign o_fwd_tag   = i_tag;
  assign o_fwd_a     = i_a;
  assign o_fwd_b     = i_b;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_drop     <= 1'b0;
      o_done     <= 1'b0;
      hold_vld_q <= 1'b0;
    end else begin
      o_drop     <= i_start && busy_c;
      o_done     <= i_lin_done || i_mul_done || hold_vld_q;
      hold_vld_q <= i_lin_done && i_mul_done;
    end
  end

  // Linear result wins a tie, the multiply result goes out one cycle later
  always_ff @(posedge i_clk) begin
    if (i_lin_done && i_mul_done) begin
      hold_tag_q <= i_mul_tag;
      hold_r_q   <= i_mul_r.raw;
    end
    if (i_lin_done) begin
      o_done_tag <= i_lin_tag;
      o_result   <= i_lin_r.raw;
    end else if (hold_vld_q) begin
      o_done_tag <= hold_tag_q;
      o_result   <= hold_r_q;
    end else if (i_mul_done) begin
      o_done_tag <= i_mul_tag;
      o_result   <= i_mul_r.raw;
    end
  end

endmodule

//--- hw/fp2_arith_top.sv
// Fp2 arithmetic top, add/sub/mul peers sharing one Fp add/sub unit
`timescale 1ns/1ns
`include "fp2_config.svh"

module fp2_arith_top (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_start,
  input  fp2_op_pkg::fp2_op_e   i_op,
  input  logic [`TAG_BITS-1:0]  i_tag,
  input  logic [2*`FP_BITS-1:0] i_a,
  input  logic [2*`FP_BITS-1:0] i_b,
  output logic                  o_done,
  output logic [`TAG_BITS-1:0]  o_done_tag,
  output logic [2*`FP_BITS-1:0] o_result,
  output logic                  o_drop,
  output logic                  o_lin_busy,
  output logic                  o_mul_busy
);
  import fp_field_pkg::*;
  import fp2_op_pkg::*;

  // Router to peers
  logic                 lin_start;
  logic                 lin_sub;
  logic                 mul_start;
  logic [`TAG_BITS-1:0] fwd_tag;
  fe2_u                 fwd_a;
  fe2_u                 fwd_b;
  logic                 lin_done;
  logic [`TAG_BITS-1:0] lin_tag;
  fe2_u                 lin_r;
  logic                 mul_done;
  logic [`TAG_BITS-1:0] mul_tag;
  fe2_u                 mul_r;

  // Peers to arbiter
  logic    lin_req;
  fe_t     lin_ua;
  fe_t     lin_ub;
  logic    lin_usub;
  logic    lin_gnt;
  logic    lin_resp;
  fe_t     lin_ur;
  logic    mul_req;
  fe_t     mul_ua;
  fe_t     mul_ub;
  logic    mul_usub;
  logic    mul_gnt;
  logic    mul_resp;
  fe_t     mul_ur;

  // Arbiter to add/sub unit and back
  logic    u_vld;
  logic    u_sub;
  fe_t     u_a;
  fe_t     u_b;
  req_id_e u_id;
  logic    r_vld;
  fe_t     r_r;
  req_id_e r_id;

  // Multiply peer to Fp multiplier
  logic       m_vld;
  fe_t        m_a;
  fe_t        m_b;
  logic [1:0] m_idx;
  logic       p_vld;
  fe_t        p_p;
  logic [1:0] p_idx;

  fp2_op_router u_router (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(i_start), .i_op(i_op), .i_tag(i_tag),
    .i_a(i_a), .i_b(i_b), .o_drop(o_drop),
    .o_lin_start(lin_start), .o_lin_sub(lin_sub), .o_mul_start(mul_start),
    .o_fwd_tag(fwd_tag), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b),
    .i_lin_busy(o_lin_busy), .i_lin_done(lin_done), .i_lin_tag(lin_tag), .i_lin_r(lin_r),
    .i_mul_busy(o_mul_busy), .i_mul_done(mul_done), .i_mul_tag(mul_tag), .i_mul_r(mul_r),
    .o_done(o_done), .o_done_tag(o_done_tag), .o_result(o_result)
  );

  fp2_linear_seq u_lin (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(lin_start), .i_sub(lin_sub), .i_tag(fwd_tag),
    .i_a(fwd_a), .i_b(fwd_b), .o_busy(o_lin_busy), .o_done(lin_done), .o_tag(lin_tag),
    .o_r(lin_r), .o_req(lin_req), .o_ua(lin_ua), .o_ub(lin_ub), .o_usub(lin_usub),
    .i_gnt(lin_gnt), .i_resp(lin_resp), .i_ur(lin_ur)
  );

  fp2_mul_seq u_mul (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(mul_start), .i_tag(fwd_tag),
    .i_a(fwd_a), .i_b(fwd_b), .o_busy(o_mul_busy), .o_done(mul_done), .o_tag(mul_tag),
    .o_r(mul_r), .o_mvld(m_vld), .o_ma(m_a), .o_mb(m_b), .o_midx(m_idx),
    .i_pvld(p_vld), .i_p(p_p), .i_pidx(p_idx),
    .o_req(mul_req), .o_ua(mul_ua), .o_ub(mul_ub), .o_usub(mul_usub),
    .i_gnt(mul_gnt), .i_resp(mul_resp), .i_ur(mul_ur)
  );

  fp_res_arbiter u_arb (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_req_lin(lin_req), .i_a_lin(lin_ua), .i_b_lin(lin_ub), .i_sub_lin(lin_usub),
    .o_gnt_lin(lin_gnt), .o_resp_lin(lin_resp), .o_r_lin(lin_ur),
    .i_req_mul(mul_req), .i_a_mul(mul_ua), .i_b_mul(mul_ub), .i_sub_mul(mul_usub),
    .o_gnt_mul(mul_gnt), .o_resp_mul(mul_resp), .o_r_mul(mul_ur),
    .o_vld(u_vld), .o_sub(u_sub), .o_a(u_a), .o_b(u_b), .o_id(u_id),
    .i_vld(r_vld), .i_r(r_r), .i_id(r_id)
  );

  fp_mod_addsub u_addsub (
    .i_clk(i_clk), .i_rst(i_rst), .i_vld(u_vld), .i_sub(u_sub), .i_a(u_a), .i_b(u_b),
    .i_id(u_id), .o_vld(r_vld), .o_r(r_r), .o_id(r_id)
  );

  fp_mod_mul u_mul_unit (
    .i_clk(i_clk), .i_rst(i_rst), .i_vld(m_vld), .i_a(m_a), .i_b(m_b), .i_idx(m_idx),
    .o_vld(p_vld), .o_p(p_p), .o_idx(p_idx)
  );

endmodule

//--- verif/fp2_arith_asserts.sv
// Protocol assertions bound to the Fp2 arithmetic top level
`timescale 1ns/1ns

module fp2_arith_asserts (
  input logic i_clk,
  input logic i_rst,
  input logic i_done,
  input logic i_drop,
  input logic i_lin_req,
  input logic i_lin_gnt,
  input logic i_mul_req,
  input logic i_mul_gnt
);

  // Number of assertion failures so far
  int fail_count = 0;

  // A cycle carries either a result or a drop
  a_done_drop: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_done && i_drop))
    else begin
      $error("done and drop strobes in the same cycle");
      fail_count++;
    end

  a_one_grant: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_lin_gnt && i_mul_gnt))
    else begin
      $error("arbiter granted both requesters");
      fail_count++;
    end

  // Requests wait for their grant
  a_lin_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_lin_req && !i_lin_gnt |=> i_lin_req)
    else begin
      $error("linear request dropped before its grant");
      fail_count++;
    end

  a_mul_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_req && !i_mul_gnt |=> i_mul_req)
    else begin
      $error("multiply request dropped before its grant");
      fail_count++;
    end

  // Strobes and grants stay low while reset is applied
  a_reset_quiet: assert property (@(posedge i_clk)
    i_rst |=> !(i_done || i_drop || i_lin_gnt || i_mul_gnt))
    else begin
      $error("strobe or grant active during reset");
      fail_count++;
    end

endmodule

bind fp2_arith_top fp2_arith_asserts u_asserts (
  .i_clk(i_clk), .i_rst(i_rst), .i_done(o_done), .i_drop(o_drop),
  .i_lin_req(lin_req), .i_lin_gnt(lin_gnt), .i_mul_req(mul_req), .i_mul_gnt(mul_gnt)
);

//--- verif/fp2_arith_tb.sv
// Table driven Fp2 arithmetic testbench with a reference model and tag scoreboard
`timescale 1ns/1ns
`include "fp2_config.svh"

module fp2_arith_tb;
  import fp2_op_pkg::*;

  localparam int          N_FIXED    = 11;
  localparam int          N_RAND     = 40;
  localparam int          N_ROWS     = N_FIXED + N_RAND;
  localparam int          N_TAGS     = 2 ** `TAG_BITS;
  localparam int          WAIT_LIMIT = 200;
  localparam logic [31:0] P          = `FP_MODULUS;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_start;
  fp2_op_e               i_op;
  logic [`TAG_BITS-1:0]  i_tag;
  logic [2*`FP_BITS-1:0] i_a;
  logic [2*`FP_BITS-1:0] i_b;
  logic                  o_done;
  logic [`TAG_BITS-1:0]  o_done_tag;
  logic [2*`FP_BITS-1:0] o_result;
  logic                  o_drop;
  logic                  o_lin_busy;
  logic                  o_mul_busy;

  // Stimulus table with one start per row
  fp2_op_e               row_op   [N_ROWS];
  logic [`TAG_BITS-1:0]  row_tag  [N_ROWS];
  logic [2*`FP_BITS-1:0] row_a    [N_ROWS];
  logic [2*`FP_BITS-1:0] row_b    [N_ROWS];
  int                    row_gap  [N_ROWS];
  bit                    row_drop [N_ROWS];

  // Scoreboard indexed by tag
  bit                    pending  [N_TAGS];
  logic [2*`FP_BITS-1:0] expected [N_TAGS];
  int                    outstanding;
  bit                    exp_drop;
  logic [31:0]           lcg_state;

  fp2_arith_top dut0 (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(i_start), .i_op(i_op), .i_tag(i_tag),
    .i_a(i_a), .i_b(i_b), .o_done(o_done), .o_done_tag(o_done_tag), .o_result(o_result),
    .o_drop(o_drop), .o_lin_busy(o_lin_busy), .o_mul_busy(o_mul_busy)
  );

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Fp2 result from the field rules with i^2 = -1
  function automatic logic [31:0] reference_result(fp2_op_e op, logic [31:0] a,
                                                   logic [31:0] b);
    logic [31:0] ar;
    logic [31:0] ai;
    logic [31:0] br;
    logic [31:0] bi;
    logic [31:0] re;
    logic [31:0] im;
    ar = {16'd0, a[15:0]};
    ai = {16'd0, a[31:16]};
    br = {16'd0, b[15:0]};
    bi = {16'd0, b[31:16]};
    case (op)
      OP_ADD: begin
        re = (ar + br) % P;
        im = (ai + bi) % P;
      end
      OP_SUB: begin
        re = (ar + P - br) % P;
        im = (ai + P - bi) % P;
      end
      default: begin
        re = ((ar * br) % P + P - (ai * bi) % P) % P;
        im = ((ar * bi) % P + (ai * br) % P) % P;
      end
    endcase
    return {im[15:0], re[15:0]};
  endfunction

  function automatic logic target_busy(fp2_op_e op);
    return (op == OP_MUL) ? o_mul_busy : o_lin_busy;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %0t ns: %s, got %0h expected %0h",
                                  $time, what, got, exp));
    end
  endtask

  // One clock step with outputs checked at the falling edge where they are stable
  task automatic tick();
    @(negedge i_clk);
    if (dut0.u_asserts.fail_count != 0) begin
      stop_with_failure("A protocol assertion in the bound checker failed");
    end
    check_equal(o_drop, exp_drop, "drop strobe");
    exp_drop = 1'b0;
    if (o_done) begin
      if (!pending[o_done_tag]) begin
        stop_with_failure($sformatf("Done with tag %0d arrived but no start is waiting for it",
                                    o_done_tag));
      end
      check_equal(o_result, expected[o_done_tag], $sformatf("result of tag %0d", o_done_tag));
      pending[o_done_tag] = 1'b0;
      outstanding--;
    end
  endtask

  task automatic wait_peer_idle(input fp2_op_e op);
    int n;
    n = 0;
    while (target_busy(op)) begin
      if (n == WAIT_LIMIT) stop_with_failure("Timeout waiting for a peer to become idle");
      tick();
      n++;
    end
  endtask

  task automatic wait_tag_free(input logic [`TAG_BITS-1:0] tag);
    int n;
    n = 0;
    while (pending[tag]) begin
      if (n == WAIT_LIMIT) stop_with_failure("Timeout waiting for a tag to complete");
      tick();
      n++;
    end
  endtask

  task automatic add_row(input int idx, input fp2_op_e op, input logic [`TAG_BITS-1:0] tag,
                         input logic [31:0] a, input logic [31:0] b, input int gap,
                         input bit drop);
    row_op[idx]   = op;
    row_tag[idx]  = tag;
    row_a[idx]    = a;
    row_b[idx]    = b;
    row_gap[idx]  = gap;
    row_drop[idx] = drop;
  endtask

  task automatic load_rows();
    logic [31:0] re;
    logic [31:0] im;
    // Wraparound of (p-1)+1 and 0-1 in both halves
    add_row(0, OP_ADD, 4'd1, 32'h0001_FFEE, 32'hFFEE_0001, 0, 1'b0);
    add_row(1, OP_SUB, 4'd2, 32'h0005_0000, 32'h0007_0001, 0, 1'b0);
    // Second linear start while the first is running
    add_row(2, OP_ADD, 4'd10, 32'h1234_8000, 32'hF000_9000, 0, 1'b0);
    add_row(3, OP_ADD, 4'd11, 32'h0001_0001, 32'h0002_0002, 0, 1'b1);
    // i * i = -1
    add_row(4, OP_MUL, 4'd3, 32'h0001_0000, 32'h0001_0000, 0, 1'b0);
    add_row(5, OP_MUL, 4'd4, 32'hFFEE_FFEE, 32'h04D2_9C40, 0, 1'b0);
    // Multiply then add at once and then a dropped multiply
    add_row(6, OP_MUL, 4'd5, 32'h0003_0002, 32'h0005_0004, 0, 1'b0);
    add_row(7, OP_ADD, 4'd6, 32'hFFEE_0000, 32'h0002_FFEE, 0, 1'b0);
    add_row(8, OP_MUL, 4'd7, 32'h0009_0009, 32'h0009_0009, 0, 1'b1);
    // Gap of 6 lines the subtract up with the multiply's shared-unit jobs
    add_row(9, OP_MUL, 4'd8, 32'hABCD_1234, 32'h7FFF_FFED, 6, 1'b0);
    add_row(10, OP_SUB, 4'd9, 32'h0000_0001, 32'hFFEE_FFEE, 0, 1'b0);
    for (int i = N_FIXED; i < N_ROWS; i++) begin
      row_op[i]   = fp2_op_e'(next_random() % 3);
      row_tag[i]  = i[`TAG_BITS-1:0];
      re          = (next_random() >> 8) % P;
      im          = (next_random() >> 8) % P;
      row_a[i]    = {im[15:0], re[15:0]};
      re          = (next_random() >> 8) % P;
      im          = (next_random() >> 8) % P;
      row_b[i]    = {im[15:0], re[15:0]};
      row_gap[i]  = (next_random() >> 16) % 4;
      row_drop[i] = 1'b0;
    end
  endtask

  task automatic apply_row(input int idx);
    if (row_drop[idx]) begin
      check_equal(target_busy(row_op[idx]), 1'b1, "busy flag before a start meant to drop");
    end else begin
      wait_tag_free(row_tag[idx]);
      wait_peer_idle(row_op[idx]);
      pending[row_tag[idx]]  = 1'b1;
      expected[row_tag[idx]] = reference_result(row_op[idx], row_a[idx], row_b[idx]);
      outstanding++;
    end
    i_start  = 1'b1;
    i_op     = row_op[idx];
    i_tag    = row_tag[idx];
    i_a      = row_a[idx];
    i_b      = row_b[idx];
    exp_drop = row_drop[idx];
    tick();
    i_start = 1'b0;
    repeat (row_gap[idx]) tick();
  endtask

  initial begin
    int n;
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_start     = 1'b0;
    i_op        = OP_ADD;
    i_tag       = '0;
    i_a         = '0;
    i_b         = '0;
    outstanding = 0;
    exp_drop    = 1'b0;
    lcg_state   = 32'h777b;
    for (int t = 0; t < N_TAGS; t++) begin
      pending[t]  = 1'b0;
      expected[t] = '0;
    end
    load_rows();

    repeat (10) @(negedge i_clk);
    i_rst = 1'b0;

    // Quiet after reset until the first start
    repeat (4) begin
      tick();
      check_equal(o_done, 1'b0, "done after reset");
      check_equal(o_lin_busy, 1'b0, "linear busy after reset");
      check_equal(o_mul_busy, 1'b0, "multiply busy after reset");
    end

    for (int i = 0; i < N_ROWS; i++) begin
      apply_row(i);
    end

    n = 0;
    while (outstanding != 0) begin
      if (n == WAIT_LIMIT) stop_with_failure("Timeout waiting for the last results");
      tick();
      n++;
    end
    repeat (4) tick();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- files.f
+incdir+hw
hw/fp_field_pkg.sv
hw/fp2_op_pkg.sv
hw/fp_mod_mul.sv
hw/fp_mod_addsub.sv
hw/fp_res_arbiter.sv
hw/fp2_linear_seq.sv
hw/fp2_mul_seq.sv
hw/fp2_op_router.sv
hw/fp2_arith_top.sv
verif/fp2_arith_asserts.sv
verif/fp2_arith_tb.sv
